// File: design/dsp_pkg.sv
package dsp_pkg;

    localparam int NPROC     = 2;
    localparam int PROC_W    = $clog2(NPROC);          // Core index width
    localparam int CMD_AW    = 8;
    localparam int ENV_AW    = 10;
    localparam int ENV_DW    = 16;
    localparam int AMP_W     = 12;                     // Q1.11 unsigned
    localparam int LEN_W     = 8;
    localparam int AMP_SHIFT = 11;
    localparam int DAC_W     = 16;
    localparam int PROD_W    = ENV_DW + AMP_W + 1;     // Sample times signed amp

    typedef enum logic [1:0] {
        OP_PLAY,
        OP_WAIT,
        OP_DONE
    } opcode_t;

    typedef enum logic {
        TGT_CMD,
        TGT_ENV
    } write_target_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        PLAY,
        WAIT,
        NEXT
    } core_state_t;

    // One command word, 32 bits
    typedef struct packed {
        opcode_t             opcode;
        logic [ENV_AW-1:0]   env_addr;
        logic [LEN_W-1:0]    length;
        logic [AMP_W-1:0]    amp;
    } pulse_cmd_t;

    typedef struct packed {
        logic                req;
        logic [ENV_AW-1:0]   addr;
    } env_req_t;

    typedef struct packed {
        logic                valid;
        logic signed [ENV_DW-1:0] data;
    } env_rsp_t;

    typedef struct packed {
        logic                valid;
        logic signed [DAC_W-1:0] data;
    } dac_sample_t;

endpackage

// File: design/aligned_ram.sv
`timescale 1ns/1ps

module aligned_ram #(
    parameter int DW = 32,
    parameter int AW = 8
) (
    input  logic          clk,
    input  logic          write_enable,
    input  logic [AW-1:0] write_addr,
    input  logic [DW-1:0] write_data,
    input  logic [AW-1:0] read_addr,
    output logic [DW-1:0] read_data
);

    logic [DW-1:0] mem [0:(1<<AW)-1];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
        read_data <= mem[read_addr];             // One cycle read latency
    end

endmodule

// File: design/env_arbiter.sv
`timescale 1ns/1ps

module env_arbiter import dsp_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  env_req_t          reqs [NPROC],
    output logic [NPROC-1:0]  gnt,
    output logic [ENV_AW-1:0] ram_addr,
    input  logic [ENV_DW-1:0] ram_data,
    output env_rsp_t          rsps [NPROC]
);

    logic [PROC_W-1:0] prio;                     // Core with top priority
    logic [PROC_W-1:0] gnt_idx;
    logic [PROC_W-1:0] owner_q;                  // Who gets the RAM data
    logic              pend_q;

    // Search from prio upward, first requester wins
    always_comb begin
        int   idx;
        logic found;
        gnt     = '0;
        gnt_idx = prio;
        found   = 1'b0;
        for (int k = 0; k < NPROC; k++) begin
            idx = (int'(prio) + k) % NPROC;
            if (!found && reqs[idx].req) begin
                found        = 1'b1;
                gnt[idx]     = 1'b1;
                gnt_idx      = PROC_W'(idx);
            end
        end
    end

    assign ram_addr = reqs[gnt_idx].addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio    <= '0;
            owner_q <= '0;
            pend_q  <= 1'b0;
        end else begin
            pend_q <= |gnt;
            if (|gnt) begin
                owner_q <= gnt_idx;
                prio    <= (gnt_idx == PROC_W'(NPROC - 1)) ? '0 : gnt_idx + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < NPROC; i++) begin : g_rsp
        assign rsps[i].valid = pend_q && (owner_q == PROC_W'(i));
        assign rsps[i].data  = ram_data;

        a_no_starve: assert property (@(posedge clk) disable iff (!rst_n)
            reqs[i].req |-> ##[0:NPROC-1] gnt[i]);
    end

    a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt));

endmodule

// File: design/pulse_core.sv
`timescale 1ns/1ps

module pulse_core import dsp_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [31:0]       nshot,
    output logic [CMD_AW-1:0] cmd_addr,
    input  pulse_cmd_t        cmd_data,
    output env_req_t          env_req,
    input  logic              env_gnt,
    input  env_rsp_t          env_rsp,
    output dac_sample_t       dac,
    output logic              busy
);

    core_state_t              state;
    logic [CMD_AW-1:0]        pc;
    logic [LEN_W-1:0]         issue_left;        // Requests still to raise
    logic [LEN_W-1:0]         sample_cnt;        // Samples still to return
    logic [LEN_W-1:0]         wait_cnt;
    logic [31:0]              shots_left;
    logic                     req_q;
    logic [ENV_AW-1:0]        addr_q;
    logic [AMP_W-1:0]         amp_q;
    logic                     dac_valid_q;
    logic [DAC_W-1:0]         dac_data_q;
    logic signed [PROD_W-1:0] product;
    logic signed [PROD_W-1:0] shifted;
    logic [DAC_W-1:0]         sat;

    assign cmd_addr     = pc;
    assign busy         = (state != IDLE);
    assign env_req.req  = req_q;
    assign env_req.addr = addr_q;
    assign dac.valid    = dac_valid_q;
    assign dac.data     = dac_data_q;

    // Amp is unsigned, so give it a zero sign bit
    assign product = $signed(env_rsp.data) * $signed({1'b0, amp_q});
    assign shifted = product >>> AMP_SHIFT;

    always_comb begin
        if (shifted[PROD_W-1:DAC_W-1] == '0 || shifted[PROD_W-1:DAC_W-1] == '1) begin
            sat = shifted[DAC_W-1:0];
        end else if (shifted[PROD_W-1]) begin
            sat = {1'b1, {(DAC_W-1){1'b0}}};     // Clip negative
        end else begin
            sat = {1'b0, {(DAC_W-1){1'b1}}};     // Clip positive
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            pc          <= '0;
            issue_left  <= '0;
            sample_cnt  <= '0;
            wait_cnt    <= '0;
            shots_left  <= '0;
            req_q       <= 1'b0;
            dac_valid_q <= 1'b0;
        end else begin
            dac_valid_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        pc         <= '0;
                        shots_left <= (nshot == '0) ? 32'd1 : nshot;
                        state      <= FETCH;
                    end
                end
                FETCH: state <= DECODE;          // RAM sees pc this cycle
                DECODE: begin
                    pc <= pc + 1'b1;
                    case (cmd_data.opcode)
                        OP_PLAY: begin
                            if (cmd_data.length != '0) begin
                                req_q      <= 1'b1;
                                issue_left <= cmd_data.length - 1'b1;
                                sample_cnt <= cmd_data.length;
                                state      <= PLAY;
                            end else begin
                                state <= FETCH;
                            end
                        end
                        OP_WAIT: begin
                            if (cmd_data.length != '0) begin
                                wait_cnt <= cmd_data.length;
                                state    <= WAIT;
                            end else begin
                                state <= FETCH;
                            end
                        end
                        default: state <= NEXT;  // DONE and unused code
                    endcase
                end
                PLAY: begin
                    if (req_q && env_gnt) begin
                        if (issue_left == '0) begin
                            req_q <= 1'b0;
                        end else begin
                            issue_left <= issue_left - 1'b1;
                        end
                    end
                    if (env_rsp.valid) begin
                        dac_valid_q <= 1'b1;
                        sample_cnt  <= sample_cnt - 1'b1;
                        if (sample_cnt == LEN_W'(1)) begin
                            state <= FETCH;
                        end
                    end
                end
                WAIT: begin
                    wait_cnt <= wait_cnt - 1'b1;
                    if (wait_cnt == LEN_W'(1)) begin
                        state <= FETCH;
                    end
                end
                NEXT: begin
                    if (shots_left == 32'd1) begin
                        state <= IDLE;
                    end else begin
                        shots_left <= shots_left - 1'b1;
                        pc         <= '0;
                        state      <= FETCH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            addr_q <= cmd_data.env_addr;
            amp_q  <= cmd_data.amp;
        end else if (state == PLAY && req_q && env_gnt) begin
            addr_q <= addr_q + 1'b1;             // Next sample address
        end
        if (env_rsp.valid) begin
            dac_data_q <= sat;
        end
    end

    // A sample returned outside PLAY would never reach the DAC
    a_rsp_in_play: assert property (@(posedge clk) disable iff (!rst_n)
        env_rsp.valid |-> state == PLAY);

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        env_req.req && !env_gnt |=> env_req.req && $stable(env_req.addr));

endmodule

// File: design/dsp_top.sv
`timescale 1ns/1ps

module dsp_top import dsp_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stb_start,
    input  logic [31:0]       nshot,
    input  logic              mem_write_en,
    input  write_target_t     mem_write_sel,
    input  logic [PROC_W-1:0] proc_write_sel,
    input  logic [ENV_AW-1:0] mem_write_addr,
    input  logic [31:0]       mem_write_data,
    output dac_sample_t       dac [NPROC],
    output logic [NPROC-1:0]  busy,
    output logic              done
);

    logic                start_ok;
    logic [NPROC-1:0]    busy_q;
    logic                env_wen;
    logic [CMD_AW-1:0]   cmd_addr  [NPROC];
    pulse_cmd_t          cmd_rdata [NPROC];
    env_req_t            env_reqs  [NPROC];
    env_rsp_t            env_rsps  [NPROC];
    logic [NPROC-1:0]    env_gnt;
    logic [ENV_AW-1:0]   env_raddr;
    logic [ENV_DW-1:0]   env_rdata;

    assign start_ok = stb_start && (busy == '0);     // Ignore start while running
    assign env_wen  = mem_write_en && (mem_write_sel == TGT_ENV);
    assign done     = (|busy_q) && (busy == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy;
        end
    end

    for (genvar i = 0; i < NPROC; i++) begin : g_core
        logic cmd_wen;

        assign cmd_wen = mem_write_en && (mem_write_sel == TGT_CMD)
                         && (proc_write_sel == PROC_W'(i));

        aligned_ram #(.DW($bits(pulse_cmd_t)), .AW(CMD_AW)) i_cmd_ram (
            .clk          (clk),
            .write_enable (cmd_wen),
            .write_addr   (mem_write_addr[CMD_AW-1:0]),
            .write_data   (mem_write_data),
            .read_addr    (cmd_addr[i]),
            .read_data    (cmd_rdata[i])
        );

        pulse_core i_core (
            .clk      (clk),
            .rst_n    (rst_n),
            .start    (start_ok),
            .nshot    (nshot),
            .cmd_addr (cmd_addr[i]),
            .cmd_data (cmd_rdata[i]),
            .env_req  (env_reqs[i]),
            .env_gnt  (env_gnt[i]),
            .env_rsp  (env_rsps[i]),
            .dac      (dac[i]),
            .busy     (busy[i])
        );
    end

    // Shared envelope store, low half of the write word
    aligned_ram #(.DW(ENV_DW), .AW(ENV_AW)) i_env_ram (
        .clk          (clk),
        .write_enable (env_wen),
        .write_addr   (mem_write_addr),
        .write_data   (mem_write_data[ENV_DW-1:0]),
        .read_addr    (env_raddr),
        .read_data    (env_rdata)
    );

    env_arbiter i_env_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .reqs     (env_reqs),
        .gnt      (env_gnt),
        .ram_addr (env_raddr),
        .ram_data (env_rdata),
        .rsps     (env_rsps)
    );

    a_no_write_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write_en |-> busy == '0);

endmodule

// File: bench/dsp_model.svh
`ifndef DSP_MODEL_SVH
`define DSP_MODEL_SVH

localparam int EXP_MAX = 4096;                   // Samples per core per run

pulse_cmd_t              cmd_img [NPROC][1<<CMD_AW];
logic [ENV_DW-1:0]       env_img [1<<ENV_AW];
logic signed [DAC_W-1:0] exp_mem [NPROC][EXP_MAX];
int                      exp_len [NPROC];

// Host write, as the DUT memories should see it
function automatic void mirror_write(write_target_t sel, logic [PROC_W-1:0] core,
                                     logic [ENV_AW-1:0] addr, logic [31:0] data);
    if (sel == TGT_CMD) begin
        cmd_img[core][addr[CMD_AW-1:0]] = pulse_cmd_t'(data);
    end else begin
        env_img[addr] = data[ENV_DW-1:0];                    // Low half only
    end
endfunction

// Q1.11 gain, floor shift, clip to the DAC range
function automatic logic signed [DAC_W-1:0] scale_sample(logic signed [ENV_DW-1:0] s,
                                                         logic [AMP_W-1:0] amp);
    longint p;
    p = (longint'(s) * longint'(amp)) >>> AMP_SHIFT;
    if (p > 64'sd32767) begin
        p = 64'sd32767;
    end else if (p < -64'sd32768) begin
        p = -64'sd32768;
    end
    return p[DAC_W-1:0];
endfunction

function automatic void build_expected(logic [PROC_W-1:0] core, logic [31:0] nshot_val);
    int unsigned       shots;
    logic [CMD_AW-1:0] pc;
    logic [ENV_AW-1:0] ea;
    pulse_cmd_t        c;
    bit                stop;
    shots = (nshot_val == 32'd0) ? 1 : nshot_val;          // Zero runs once
    exp_len[core] = 0;
    for (int unsigned s = 0; s < shots; s++) begin
        pc   = '0;
        stop = 1'b0;
        while (!stop) begin
            c  = cmd_img[core][pc];
            pc = pc + 1'b1;
            if (c.opcode == OP_PLAY) begin
                for (int k = 0; k < int'(c.length); k++) begin
                    ea = c.env_addr + ENV_AW'(k);
                    exp_mem[core][exp_len[core]] = scale_sample(env_img[ea], c.amp);
                    exp_len[core]++;
                end
            end else if (c.opcode != OP_WAIT) begin
                stop = 1'b1;                                 // DONE ends the shot
            end
        end
    end
endfunction

`endif

// File: bench/tb_dsp_top.sv
`timescale 1ns/1ps

module tb_dsp_top import dsp_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int SEED        = 32'hb37d;
    localparam int NUM_TESTS   = 12;
    localparam int MAX_CMDS    = 12;
    localparam int MAX_LEN     = 40;
    localparam int MAX_SHOT    = 4;
    localparam int ENV_WORDS   = 192;                // Covers 127 + MAX_LEN
    localparam int SETTLE      = 12;
    localparam int CMD_CYC     = 4 + 2 * MAX_LEN;    // Every sample loses a cycle to the peer
    localparam int RUN_CYC     = MAX_SHOT * ((MAX_CMDS + 1) * CMD_CYC + 1);
    localparam int TEST_CYC    = ENV_WORDS + 2 * (MAX_CMDS + 1) + RUN_CYC + SETTLE + 8;
    localparam int WATCHDOG_NS = (NUM_TESTS * TEST_CYC + 64) * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    logic              stb_start;
    logic [31:0]       nshot;
    logic              mem_write_en;
    write_target_t     mem_write_sel;
    logic [PROC_W-1:0] proc_write_sel;
    logic [ENV_AW-1:0] mem_write_addr;
    logic [31:0]       mem_write_data;
    dac_sample_t       dac [NPROC];
    logic [NPROC-1:0]  busy;
    logic              done;
    int                rd_ptr [NPROC];
    int                done_cnt;
    int                mismatch_cnt;
    int                fail_cnt;

    `include "dsp_model.svh"

    dsp_top i_dsp_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .stb_start      (stb_start),
        .nshot          (nshot),
        .mem_write_en   (mem_write_en),
        .mem_write_sel  (mem_write_sel),
        .proc_write_sel (proc_write_sel),
        .mem_write_addr (mem_write_addr),
        .mem_write_data (mem_write_data),
        .dac            (dac),
        .busy           (busy),
        .done           (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Outputs settle by the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < NPROC; i++) begin
                if (dac[i].valid) begin
                    if (rd_ptr[i] >= exp_len[i]) begin
                        $display("Error at %0t: core %0d sent a sample beyond its %0d expected",
                                 $time, i, exp_len[i]);
                        fail_cnt++;
                    end else if (dac[i].data !== exp_mem[i][rd_ptr[i]]) begin
                        $display("Mismatch at %0t: dac[%0d].data got %0d expected %0d",
                                 $time, i, dac[i].data, exp_mem[i][rd_ptr[i]]);
                        mismatch_cnt++;
                    end
                    rd_ptr[i]++;
                end
            end
            if (done) begin
                done_cnt++;
                if (busy != '0) begin
                    $display("Error at %0t: done strobe while a core is still busy", $time);
                    fail_cnt++;
                end
            end
        end
    end

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (busy != '0 || done) begin
                $display("Error at %0t: busy or done high with no start", $time);
                fail_cnt++;
            end
        end
    endtask

    task automatic write_word(input write_target_t sel, input logic [PROC_W-1:0] core,
                              input logic [ENV_AW-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        mem_write_en   <= 1'b1;
        mem_write_sel  <= sel;
        proc_write_sel <= core;
        mem_write_addr <= addr;
        mem_write_data <= data;
        mirror_write(sel, core, addr, data);
    endtask

    // Kind 0 is DONE only, 1 plays only, 2 mixes PLAY, WAIT and zero lengths
    task automatic program_core(input logic [PROC_W-1:0] core, input int kind,
                                input bit long_wait);
        int         n;
        int         pick;
        pulse_cmd_t c;
        n = (kind == 0) ? 0 : $urandom_range(1, MAX_CMDS);
        for (int k = 0; k < n; k++) begin
            pick       = (kind == 2) ? $urandom_range(0, 3) : 0;
            c.opcode   = (pick == 3) ? OP_WAIT : OP_PLAY;
            c.env_addr = ENV_AW'($urandom_range(0, 127));     // Both cores overlap here
            c.length   = LEN_W'($urandom_range(1, MAX_LEN));
            c.amp      = AMP_W'($urandom);                    // Gain up to 2 so many samples clip
            if (pick == 2 || (pick == 3 && $urandom_range(0, 1) == 0)) begin
                c.length = '0;
            end
            if (k == 0 && long_wait) begin
                c.opcode = OP_WAIT;                           // Keeps the core busy early
                c.length = LEN_W'($urandom_range(8, 20));
            end
            write_word(TGT_CMD, core, ENV_AW'(k), 32'(c));
        end
        c        = '0;
        c.opcode = OP_DONE;
        write_word(TGT_CMD, core, ENV_AW'(n), 32'(c));
    endtask

    task automatic run_test(input int t);
        int          kind0;
        int          kind1;
        bit          extra_start;
        logic [31:0] shots;
        extra_start = (t % 2 == 1);
        kind0       = (t % 3 == 0) ? 1 : t % 3;
        kind1       = extra_start ? 0 : t % 3;                // Core 1 alone idles early
        shots       = (t % 4 == 0) ? 32'd0 : (t % 4 == 1) ? 32'd1 : $urandom_range(1, MAX_SHOT);
        for (int a = 0; a < ENV_WORDS; a++) begin
            write_word(TGT_ENV, '0, ENV_AW'(a), $urandom);
        end
        program_core(1'b0, kind0, extra_start);
        program_core(1'b1, kind1, 1'b0);
        @(posedge clk);
        mem_write_en <= 1'b0;
        for (int i = 0; i < NPROC; i++) begin
            build_expected(PROC_W'(i), shots);
            rd_ptr[i] = 0;
        end
        done_cnt = 0;
        @(posedge clk);
        stb_start <= 1'b1;
        nshot     <= shots;
        @(posedge clk);
        stb_start <= 1'b0;
        if (extra_start) begin
            do begin
                @(negedge clk);
            end while (busy[1]);                              // Core 0 still in its long wait
            @(posedge clk);
            stb_start <= 1'b1;                                // Must be ignored
            @(posedge clk);
            stb_start <= 1'b0;
            @(negedge clk);
            if (busy[1]) begin
                $display("Error at %0t: test %0d core 1 restarted while core 0 was busy",
                         $time, t);
                fail_cnt++;
            end
        end
        while (done_cnt == 0) @(posedge clk);
        repeat (SETTLE) @(posedge clk);
        for (int i = 0; i < NPROC; i++) begin
            if (rd_ptr[i] != exp_len[i]) begin
                $display("Error at %0t: test %0d core %0d sent %0d samples, expected %0d",
                         $time, t, i, rd_ptr[i], exp_len[i]);
                fail_cnt++;
            end
        end
        if (done_cnt != 1 || busy != '0) begin
            $display("Error at %0t: test %0d saw %0d done strobes, busy %b after the run",
                     $time, t, done_cnt, busy);
            fail_cnt++;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n          = 1'b0;
        stb_start      = 1'b0;
        nshot          = '0;
        mem_write_en   = 1'b0;
        mem_write_sel  = TGT_CMD;
        proc_write_sel = '0;
        mem_write_addr = '0;
        mem_write_data = '0;
        mismatch_cnt   = 0;
        fail_cnt       = 0;
        done_cnt       = 0;
        for (int i = 0; i < NPROC; i++) begin
            exp_len[i] = 0;
            rd_ptr[i]  = 0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        check_idle(24);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: tb.f
+incdir+bench
design/dsp_pkg.sv
design/aligned_ram.sv
design/env_arbiter.sv
design/pulse_core.sv
design/dsp_top.sv
bench/tb_dsp_top.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_dsp_top \
    -Mdir obj_dir -o tb_dsp_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_dsp_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
if ! grep -q "PASS: all tests" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0
